//--- src/replay_pkg.sv
package replay_pkg;

  // APB address bus width
  localparam int APB_ADDR_W = 8;

  // Accepted word counter width
  localparam int COUNT_W = 16;

  // Register map
  // Write-only data register feeding the stream
  localparam logic [APB_ADDR_W-1:0] REG_DATA = 8'h00;
  // Read-only count of words taken by the buffer
  localparam logic [APB_ADDR_W-1:0] REG_COUNT = 8'h04;

  // Bits for a counter or index over n values, never less than one
  function automatic int cnt_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Sum width for words of data_w bits added up words times
  // Growth is the bits needed to count the words
  function automatic int sum_width(input int data_w, input int words);
    return data_w + $clog2(words);
  endfunction

endpackage

//--- src/simple_dual_port_ram.sv
module simple_dual_port_ram #(
  parameter int DATA_WIDTH = 16,
  parameter int SIZE = 4,
  parameter int ADDR_WIDTH = 2
) (
  input  logic                  clk,
  // Write port
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_din,
  input  logic                  wr_en,
  // Read port, data one cycle after the address
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_dout
);

  // Storage, one word per block slot
  logic [DATA_WIDTH-1:0] mem [SIZE];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_din;
    end
  end

  // Registered read, old data if the same slot is written this cycle
  always_ff @(posedge clk) begin
    rd_dout <= mem[rd_addr];
  end

endmodule

//--- src/apb_word_loader.sv
module apb_word_loader #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                            clk,
  input  logic                            rst,
  // APB slave side
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [replay_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [DATA_WIDTH-1:0]           pwdata,
  output logic [DATA_WIDTH-1:0]           prdata,
  output logic                            pready,
  output logic                            pslverr,
  // Stream toward the repeat buffer
  output logic [DATA_WIDTH-1:0]           in_data,
  output logic                            in_valid,
  input  logic                            in_ready
);

  import replay_pkg::*;

  logic               access;
  logic               data_wr;
  logic               count_rd;
  logic [COUNT_W-1:0] count;

  // Access phase of a transfer
  assign access = psel && penable;

  // Decode the two legal accesses
  assign data_wr = access && pwrite && (paddr == REG_DATA);
  assign count_rd = access && !pwrite && (paddr == REG_COUNT);

  // Write data goes straight out as a stream word
  // Held by the master for the whole access phase so it stays stable
  assign in_valid = data_wr;
  assign in_data = pwdata;

  // Data write waits for the buffer and anything else ends at once
  assign pready = data_wr ? in_ready : access;

  // Wrong address or wrong direction
  assign pslverr = access && !data_wr && !count_rd;

  // Read data only for a count read
  assign prdata = count_rd ? DATA_WIDTH'(count) : '0;

  // Words taken by the buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (in_valid && in_ready) begin
      count <= count + 1'b1;
    end
  end

  // Error ends the transfer at once
  a_err_ready: assert property (
    @(posedge clk) disable iff (rst)
    pslverr |-> pready
  );

endmodule

//--- src/repeat_circular_buffer.sv
module repeat_circular_buffer #(
  parameter int DATA_WIDTH = 16,
  parameter int REPEAT = 3,
  parameter int SIZE = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  // Block words in
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  // Replayed words out
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  import replay_pkg::*;

  localparam int ADDR_W = cnt_width(SIZE);
  // Write pointer also has to hold SIZE itself
  localparam int PTR_W = $clog2(SIZE + 1);
  localparam int REP_W = cnt_width(REPEAT);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(SIZE - 1);
  localparam logic [PTR_W-1:0] FULL = PTR_W'(SIZE);
  localparam logic [REP_W-1:0] LAST_REP = REP_W'(REPEAT - 1);

  // Write and read side state
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W-1:0]      fill;
  logic [REP_W-1:0]      rep;
  logic                  rd_pending;
  // Two-entry output skid, out_reg is always the head
  logic [DATA_WIDTH-1:0] out_reg;
  logic [DATA_WIDTH-1:0] extra_reg;
  logic                  out_vld;
  logic                  extra_vld;
  // RAM and handshake helpers
  logic [DATA_WIDTH-1:0] rd_dout;
  logic                  wr_en;
  logic                  rd_en;
  logic                  pop;
  logic                  push;
  logic [1:0]            occ_next;

  // Replay of the first pass depends on a later pass to free slots
  if (REPEAT < 2) begin : g_repeat_check
    $error("repeat_circular_buffer needs REPEAT of at least 2");
  end

  // Room while the block is incomplete and its slot is free
  // During the last replay, fill drops as old slots are read
  assign in_ready = (wr_ptr != FULL) && (fill != FULL);
  assign wr_en = in_valid && in_ready;

  assign pop = out_vld && out_ready;
  assign push = rd_pending;

  // Skid occupancy after this edge, not counting a read issued now
  assign occ_next = 2'(out_vld) + 2'(extra_vld) + 2'(push) - 2'(pop);

  // Read only if its data can land next cycle even without a pop
  // First pass trails the write pointer
  assign rd_en = (occ_next < 2'd2) && ((rep != '0) || (rd_ptr < wr_ptr));

  assign out_data = out_reg;
  assign out_valid = out_vld;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      rep <= '0;
      rd_pending <= 1'b0;
      out_vld <= 1'b0;
      extra_vld <= 1'b0;
    end else begin
      // Block written, restart once the last replay begins
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end else if (wr_ptr == FULL && rep == LAST_REP) begin
        wr_ptr <= '0;
      end

      // Slot is released only by its read in the last replay
      fill <= fill + PTR_W'(wr_en) - PTR_W'(rd_en && rep == LAST_REP);

      // RAM output valid one cycle after the address
      rd_pending <= rd_en;

      // Read pointer wraps per pass, rep wraps per block
      if (rd_en) begin
        if (rd_ptr == LAST_SLOT) begin
          rd_ptr <= '0;
          rep <= (rep == LAST_REP) ? '0 : rep + 1'b1;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end

      // Skid flags
      if (pop) begin
        out_vld <= extra_vld || push;
        extra_vld <= extra_vld && push;
      end else if (push) begin
        out_vld <= 1'b1;
        extra_vld <= extra_vld || out_vld;
      end
    end
  end

  // Skid data, shifts toward out_reg on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      if (extra_vld) begin
        out_reg <= extra_reg;
      end else if (push) begin
        out_reg <= rd_dout;
      end
      if (extra_vld && push) begin
        extra_reg <= rd_dout;
      end
    end else if (push) begin
      // Head still waiting, new word goes behind it
      if (out_vld) begin
        extra_reg <= rd_dout;
      end else begin
        out_reg <= rd_dout;
      end
    end
  end

  simple_dual_port_ram #(
    .DATA_WIDTH(DATA_WIDTH),
    .SIZE      (SIZE),
    .ADDR_WIDTH(ADDR_W)
  ) u_ram (
    .clk    (clk),
    .wr_addr(wr_ptr[ADDR_W-1:0]),
    .wr_din (in_data),
    .wr_en  (wr_en),
    .rd_addr(rd_ptr[ADDR_W-1:0]),
    .rd_dout(rd_dout)
  );

  // Stalled output holds its word
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

//--- src/pass_accumulator.sv
module pass_accumulator #(
  parameter int DATA_WIDTH = 16,
  parameter int REPEAT = 3,
  parameter int SIZE = 4
) (
  input  logic                                          clk,
  input  logic                                          rst,
  // Replayed stream
  input  logic [DATA_WIDTH-1:0]                         out_data,
  input  logic                                          out_valid,
  output logic                                          out_ready,
  input  logic                                          enable,
  // One report per pass
  output logic [replay_pkg::sum_width(DATA_WIDTH, SIZE)-1:0] pass_sum,
  output logic [replay_pkg::cnt_width(REPEAT)-1:0]     pass_index,
  output logic                                          pass_valid
);

  import replay_pkg::*;

  localparam int SUM_W = sum_width(DATA_WIDTH, SIZE);
  localparam int CNT_W = cnt_width(SIZE);
  localparam int IDX_W = cnt_width(REPEAT);

  logic [CNT_W-1:0] word_cnt;
  logic [SUM_W-1:0] run_sum;
  logic [IDX_W-1:0] cur_pass;
  logic             accept;
  logic             last_word;

  // Sink takes words only while enabled
  assign out_ready = enable;
  assign accept = out_valid && enable;
  assign last_word = (word_cnt == CNT_W'(SIZE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      word_cnt <= '0;
      run_sum <= '0;
      cur_pass <= '0;
      pass_index <= '0;
      pass_valid <= 1'b0;
    end else begin
      pass_valid <= accept && last_word;
      if (accept) begin
        if (last_word) begin
          // Pass done, report its index and start over
          word_cnt <= '0;
          run_sum <= '0;
          pass_index <= cur_pass;
          cur_pass <= (cur_pass == IDX_W'(REPEAT - 1)) ? '0 : cur_pass + 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
          run_sum <= run_sum + SUM_W'(out_data);
        end
      end
    end
  end

  // Final sum includes the word taken on the last beat
  always_ff @(posedge clk) begin
    if (accept && last_word) begin
      pass_sum <= run_sum + SUM_W'(out_data);
    end
  end

  a_index_range: assert property (
    @(posedge clk) disable iff (rst)
    pass_index < REPEAT
  );

endmodule

//--- src/replay_top.sv
module replay_top #(
  parameter int DATA_WIDTH = 16,
  parameter int REPEAT = 3,
  parameter int SIZE = 4
) (
  input  logic                                          clk,
  input  logic                                          rst,
  // APB slave
  input  logic                                          psel,
  input  logic                                          penable,
  input  logic                                          pwrite,
  input  logic [replay_pkg::APB_ADDR_W-1:0]             paddr,
  input  logic [DATA_WIDTH-1:0]                         pwdata,
  output logic [DATA_WIDTH-1:0]                         prdata,
  output logic                                          pready,
  output logic                                          pslverr,
  // Downstream stall
  input  logic                                          sink_stall,
  // Pass reports
  output logic [replay_pkg::sum_width(DATA_WIDTH, SIZE)-1:0] pass_sum,
  output logic [replay_pkg::cnt_width(REPEAT)-1:0]     pass_index,
  output logic                                          pass_valid
);

  // Loader to buffer
  logic [DATA_WIDTH-1:0] in_data;
  logic                  in_valid;
  logic                  in_ready;
  // Buffer to accumulator
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_valid;
  logic                  out_ready;
  logic                  acc_enable;

  // Stall blocks the sink
  assign acc_enable = !sink_stall;

  apb_word_loader #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_loader (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .in_data (in_data),
    .in_valid(in_valid),
    .in_ready(in_ready)
  );

  repeat_circular_buffer #(
    .DATA_WIDTH(DATA_WIDTH),
    .REPEAT    (REPEAT),
    .SIZE      (SIZE)
  ) u_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  pass_accumulator #(
    .DATA_WIDTH(DATA_WIDTH),
    .REPEAT    (REPEAT),
    .SIZE      (SIZE)
  ) u_acc (
    .clk       (clk),
    .rst       (rst),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .enable    (acc_enable),
    .pass_sum  (pass_sum),
    .pass_index(pass_index),
    .pass_valid(pass_valid)
  );

endmodule

//--- testbench/replay_tb.sv
module replay_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import replay_pkg::*;

  localparam int DATA_WIDTH = 16;
  localparam int REPEAT = 3;
  localparam int SIZE = 4;
  // Sum grows by the bits needed to count the words of a block
  localparam int SUM_W = DATA_WIDTH + $clog2(SIZE);
  localparam int IDX_W = $clog2(REPEAT);
  localparam int NUM_BLOCKS = 8;
  localparam int TOTAL_PASSES = NUM_BLOCKS * REPEAT;
  localparam int HOLD_CYCLES = 30;
  localparam int STALL_LEN = 256;
  localparam int TIMEOUT_CYCLES = NUM_BLOCKS * REPEAT * SIZE * 40 + HOLD_CYCLES + 200;
  localparam logic [APB_ADDR_W-1:0] REG_UNUSED = 8'h08;

  logic                  clk;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [DATA_WIDTH-1:0] pwdata;
  logic [DATA_WIDTH-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  sink_stall;
  logic [SUM_W-1:0]      pass_sum;
  logic [IDX_W-1:0]      pass_index;
  logic                  pass_valid;

  // Scoreboard state
  int errors = 0;
  int writes_done = 0;
  int blocks_written = 0;
  int blk_words = 0;
  int pass_cnt;
  int pass_blk;
  int exp_idx;
  int stall_mode = 0;
  int stall_pos = 0;
  logic hold_phase = 1'b0;
  logic stall_pat [STALL_LEN];
  // Expected sum of each block filled in as its words are written
  logic [SUM_W-1:0] exp_sums [NUM_BLOCKS];
  logic [SUM_W-1:0] exp_sum;
  logic [SUM_W-1:0] blk_sum = '0;
  // APB transfer result taken at the rising edge
  logic xfer_done = 1'b0;
  logic xfer_err = 1'b0;
  logic access;
  logic legal;

  replay_top #(
    .DATA_WIDTH(DATA_WIDTH),
    .REPEAT    (REPEAT),
    .SIZE      (SIZE)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .sink_stall(sink_stall),
    .pass_sum  (pass_sum),
    .pass_index(pass_index),
    .pass_valid(pass_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign access = psel && penable;
  // Only a data write and a count read are legal
  assign legal = (pwrite && paddr == REG_DATA) || (!pwrite && paddr == REG_COUNT);
  assign exp_sum = (pass_blk < NUM_BLOCKS) ? exp_sums[pass_blk] : '0;

  always @(posedge clk) begin
    xfer_done <= access && pready;
    xfer_err <= pslverr;
  end

  // Block and pass the next report should carry
  always @(posedge clk) begin
    if (rst) begin
      pass_cnt <= 0;
      pass_blk <= 0;
      exp_idx <= 0;
    end else if (pass_valid) begin
      pass_cnt <= pass_cnt + 1;
      if (exp_idx == REPEAT - 1) begin
        exp_idx <= 0;
        pass_blk <= pass_blk + 1;
      end else begin
        exp_idx <= exp_idx + 1;
      end
    end
  end

  // Sink stall follows a random pattern or is held high
  always @(negedge clk) begin
    if (stall_mode == 1) begin
      sink_stall = stall_pat[stall_pos];
      stall_pos = (stall_pos + 1) % STALL_LEN;
    end else begin
      sink_stall = (stall_mode == 2);
    end
  end

  // No report for a block that was never written
  pass_known: assert property (@(posedge clk) disable iff (rst)
    pass_valid |-> pass_blk < blocks_written)
    else begin
      errors++;
      $display("Error: pass_known expected block below %0d actual block %0d",
               $sampled(blocks_written), $sampled(pass_blk));
    end

  pass_sum_ok: assert property (@(posedge clk) disable iff (rst)
    pass_valid |-> pass_sum == exp_sum)
    else begin
      errors++;
      $display("Error: pass_sum expected %0h actual %0h", $sampled(exp_sum), $sampled(pass_sum));
    end

  pass_index_ok: assert property (@(posedge clk) disable iff (rst)
    pass_valid |-> pass_index == IDX_W'(exp_idx))
    else begin
      errors++;
      $display("Error: pass_index expected %0d actual %0d", $sampled(exp_idx),
               $sampled(pass_index));
    end

  // Full buffer under a long stall keeps the write waiting
  write_held: assert property (@(posedge clk) disable iff (rst)
    hold_phase && access |-> !pready)
    else begin
      errors++;
      $display("Error: write_held expected pready 0 actual %0b", $sampled(pready));
    end

  legal_no_err: assert property (@(posedge clk) disable iff (rst)
    access && legal |-> !pslverr)
    else begin
      errors++;
      $display("Error: legal_no_err expected pslverr 0 actual %0b", $sampled(pslverr));
    end

  bad_access_err: assert property (@(posedge clk) disable iff (rst)
    access && !legal |-> pready && pslverr)
    else begin
      errors++;
      $display("Error: bad_access_err expected pready 1 pslverr 1 actual %0b %0b",
               $sampled(pready), $sampled(pslverr));
    end

  // Count equals completed data writes and ignores errored ones
  count_ok: assert property (@(posedge clk) disable iff (rst)
    access && !pwrite && paddr == REG_COUNT |-> prdata == DATA_WIDTH'(writes_done))
    else begin
      errors++;
      $display("Error: count_read expected %0d actual %0d", $sampled(writes_done),
               $sampled(prdata));
    end

  // One APB transfer with setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    do begin
      @(negedge clk);
    end while (!xfer_done);
    err = xfer_err;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // Data write whose block sum closes after SIZE words
  task automatic write_word(input logic [DATA_WIDTH-1:0] w);
    logic err;
    apb_xfer(1'b1, REG_DATA, w, err);
    if (!err) begin
      writes_done++;
      blk_sum = blk_sum + SUM_W'(w);
      blk_words++;
      if (blk_words == SIZE) begin
        exp_sums[blocks_written] = blk_sum;
        blocks_written++;
        blk_sum = '0;
        blk_words = 0;
      end
    end
  endtask

  task automatic write_block();
    logic [DATA_WIDTH-1:0] w;
    repeat (SIZE) begin
      w = DATA_WIDTH'($urandom);
      write_word(w);
    end
  endtask

  task automatic read_reg(input logic [APB_ADDR_W-1:0] addr);
    logic err;
    apb_xfer(1'b0, addr, '0, err);
  endtask

  task automatic write_bad(input logic [APB_ADDR_W-1:0] addr);
    logic err;
    apb_xfer(1'b1, addr, DATA_WIDTH'($urandom), err);
  endtask

  task automatic wait_passes();
    while (pass_cnt < blocks_written * REPEAT) begin
      @(negedge clk);
    end
  endtask

  // Mode changes on the rising edge and the stall driver picks it up next
  task automatic set_stall_mode(input int m);
    @(posedge clk);
    stall_mode = m;
    @(negedge clk);
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] w;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    sink_stall = 1'b0;
    void'($urandom(86));
    for (int i = 0; i < STALL_LEN; i++) begin
      stall_pat[i] = ($urandom % 3) == 0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Free-running sink
    repeat (3) write_block();
    wait_passes();

    // Random back-pressure
    set_stall_mode(1);
    repeat (3) write_block();
    wait_passes();
    set_stall_mode(0);

    // Under a long stall one block fits and the next word must wait
    set_stall_mode(2);
    write_block();
    hold_phase = 1'b1;
    w = DATA_WIDTH'($urandom);
    fork
      write_word(w);
      begin
        repeat (HOLD_CYCLES) @(negedge clk);
        set_stall_mode(0);
        hold_phase = 1'b0;
      end
    join
    repeat (SIZE - 1) begin
      w = DATA_WIDTH'($urandom);
      write_word(w);
    end
    wait_passes();
    read_reg(REG_COUNT);

    // Illegal accesses leave the count alone
    write_bad(REG_UNUSED);
    write_bad(REG_COUNT);
    read_reg(REG_DATA);
    read_reg(REG_UNUSED);
    read_reg(REG_COUNT);

    // Idle time exposes any extra report
    wait_passes();
    repeat (20) @(negedge clk);
    pass_total: assert (pass_cnt == TOTAL_PASSES)
      else begin
        errors++;
        $display("Error: pass_total expected %0d actual %0d", TOTAL_PASSES, pass_cnt);
      end

    $display("Done: %0d blocks, %0d passes, %0d data writes, %0d errors",
             blocks_written, pass_cnt, writes_done, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run stalled after %0d cycles with %0d of %0d passes reported",
             TIMEOUT_CYCLES, pass_cnt, TOTAL_PASSES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sim.f
src/replay_pkg.sv
src/simple_dual_port_ram.sv
src/apb_word_loader.sv
src/repeat_circular_buffer.sv
src/pass_accumulator.sv
src/replay_top.sv
testbench/replay_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= replay_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv testbench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
